/* verilog.f */
mh_pkg.sv
mh_miss_req.sv
mh_mshr.sv
mh_resp_buf.sv
mh_refill_ctrl.sv
miss_handler.sv
miss_handler_chk.sv
miss_handler_tb.sv

/* miss_handler_tb.sv */
// Table driven testbench for the miss handler with a memory model and refill monitor
`default_nettype none
`timescale 1ns/1ps

module miss_handler_tb
    import mh_pkg::*;
();

    localparam int NUM_ROWS  = 6;
    localparam int NUM_TESTS = NUM_ROWS + 1;

    typedef struct packed {
        nline_t     nline;
        tid_t       tid;
        sid_t       sid;
        word_t      word;
        way_t       way;
        logic       need_rsp;
        logic       error;
        logic [3:0] mem_dly;
        logic [3:0] grant_dly;
    } row_t;

    // Line, tid, sid, word, way, need_rsp, error, memory delay, grant delay
    row_t rows [NUM_ROWS] = '{
        '{27'h0012345, 4'd1,  3'd2, 2'd0, 2'd1, 1'b1, 1'b0, 4'd0, 4'd0},
        '{27'h3abcde6, 4'd5,  3'd3, 2'd2, 2'd3, 1'b1, 1'b0, 4'd3, 4'd2},
        '{27'h0000f13, 4'd9,  3'd0, 2'd3, 2'd0, 1'b0, 1'b0, 4'd1, 4'd4},
        '{27'h55aa5a8, 4'd12, 3'd7, 2'd1, 2'd2, 1'b1, 1'b1, 4'd2, 4'd1},
        '{27'h7fffffb, 4'd15, 3'd5, 2'd3, 2'd1, 1'b1, 1'b0, 4'd5, 4'd0},
        '{27'h1234567, 4'd3,  3'd1, 2'd1, 2'd2, 1'b0, 1'b1, 4'd0, 4'd3}
    };

    logic        clk_i;
    logic        rst_ni;
    logic        alloc_i;
    alloc_req_t  alloc_req_i;
    logic        check_i;
    nline_t      check_nline_i;
    logic        mem_req_ready_i;
    logic        mem_resp_valid_i;
    mem_rsp_t    mem_resp_i;
    logic        refill_req_ready_i;
    logic        alloc_ready_o, alloc_full_o, check_hit_o, mshr_empty_o, mshr_full_o;
    logic        mem_req_valid_o, mem_resp_ready_o, refill_req_valid_o, refill_busy_o;
    logic        refill_write_data_o, refill_write_dir_o, refill_updt_rtab_o;
    logic        refill_is_error_o, core_rsp_valid_o;
    mem_req_t    mem_req_o;
    set_t        refill_set_o;
    way_t        refill_way_o;
    word_t       refill_word_o;
    nline_t      refill_nline_o;
    data_t       refill_data_o;
    dir_entry_t  refill_dir_entry_o;
    core_rsp_t   core_rsp_o;

    row_t        cur;
    int          err_cnt;
    int          fail_tests;
    integer      seed;
    logic        in_flight;
    logic        dir_seen;
    int          wcyc;
    int          wr_cnt;
    int          rsp_cnt;

    miss_handler #(.MSHR_SETS(4), .META_DEPTH(2)) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Memory model data for one beat of a line
    function automatic data_t beat_data(nline_t n, int b);
        return {n, 2'(b), 3'b101, (32'(b) * 32'h0101_0101) ^ {5'd0, n}};
    endfunction

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Error at time %0t: %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic expect_request(input mem_req_t exp_req);
        expect_eq("mem_req_valid_o", mem_req_valid_o, 1'b1);
        expect_eq("mem_req_o", mem_req_o, exp_req);
        expect_eq("alloc_ready_o", alloc_ready_o, 1'b0);
    endtask

    task automatic report_test(input int idx, input string label, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("Test %0d %s: ok", idx, label);
        end else begin
            $display("Test %0d %s: %0d errors", idx, label, err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    // Four beats with random gaps, the last one carries the line metadata
    task automatic send_line(input row_t r);
        int   gap;
        logic taken;
        next_cycle();
        for (int b = 0; b < CL_WORDS; b++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) next_cycle();
            mem_resp_valid_i = 1'b1;
            mem_resp_i = '{data: beat_data(r.nline, b), id: r.nline[1:0], error: r.error,
                           last: (b == CL_WORDS - 1)};
            do begin
                @(negedge clk_i);
                taken = mem_resp_ready_o;
                next_cycle();
            end while (!taken);
            mem_resp_valid_i = 1'b0;
        end
    endtask

    // Refill monitor, samples in the middle of the cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (in_flight) begin
                expect_true(!mshr_empty_o, "MSHR reported empty while a miss is pending");
            end
            if (refill_busy_o) begin
                expect_eq("refill_word_o", refill_word_o, wcyc);
                expect_eq("refill_set_o", refill_set_o, cur.nline[6:0]);
                expect_eq("refill_way_o", refill_way_o, cur.way);
                expect_eq("refill_nline_o", refill_nline_o, cur.nline);
                expect_eq("refill_write_data_o", refill_write_data_o, !cur.error);
                expect_eq("refill_is_error_o", refill_is_error_o, cur.error);
                expect_eq("refill_write_dir_o", refill_write_dir_o, wcyc == CL_WORDS - 1);
                expect_eq("refill_updt_rtab_o", refill_updt_rtab_o, wcyc == CL_WORDS - 1);
                if (refill_write_data_o) begin
                    expect_eq("refill_data_o", refill_data_o, beat_data(cur.nline, wcyc));
                    wr_cnt++;
                end
                wcyc++;
            end else begin
                expect_eq("refill_write_data_o", refill_write_data_o, 1'b0);
                expect_eq("refill_write_dir_o", refill_write_dir_o, 1'b0);
                expect_eq("refill_updt_rtab_o", refill_updt_rtab_o, 1'b0);
            end
            if (refill_write_dir_o) begin
                expect_eq("refill_dir_entry_o", refill_dir_entry_o,
                          {!cur.error, cur.nline[26:7]});
                in_flight = 1'b0;
                dir_seen  = 1'b1;
            end
            if (core_rsp_valid_o) begin
                rsp_cnt++;
                expect_eq("core_rsp_o.tid", core_rsp_o.tid, cur.tid);
                expect_eq("core_rsp_o.sid", core_rsp_o.sid, cur.sid);
                expect_eq("core_rsp_o.error", core_rsp_o.error, cur.error);
                if (!cur.error) begin
                    expect_eq("core_rsp_o.data", core_rsp_o.data,
                              beat_data(cur.nline, cur.word));
                end
            end
        end
    end

    task automatic run_row(input int idx);
        int       errs_before;
        nline_t   other;
        mem_req_t exp_req;
        errs_before = err_cnt;
        cur         = rows[idx];
        other       = cur.nline ^ 27'h400;
        exp_req     = '{addr: {cur.nline, 5'b0}, len: 8'd3, id: cur.nline[1:0]};
        wcyc        = 0;
        wr_cnt      = 0;
        rsp_cnt     = 0;
        dir_seen    = 1'b0;
        alloc_req_i = '{nline: cur.nline, tid: cur.tid, sid: cur.sid, word: cur.word,
                        victim_way: cur.way, need_rsp: cur.need_rsp};
        @(negedge clk_i);
        expect_true(alloc_ready_o && !alloc_full_o, "allocation refused on a free MSHR set");
        next_cycle();
        alloc_i = 1'b1;
        next_cycle();
        alloc_i   = 1'b0;
        in_flight = 1'b1;
        // Pending-line lookups while memory holds off the request
        check_i           = 1'b1;
        check_nline_i     = cur.nline;
        alloc_req_i.nline = other;
        @(negedge clk_i);
        expect_request(exp_req);
        expect_eq("check_hit_o", check_hit_o, 1'b1);
        expect_eq("alloc_full_o", alloc_full_o, 1'b1);
        next_cycle();
        check_nline_i = other;
        @(negedge clk_i);
        expect_request(exp_req);
        expect_eq("check_hit_o", check_hit_o, 1'b0);
        next_cycle();
        check_i = 1'b0;
        repeat (cur.mem_dly) begin
            @(negedge clk_i);
            expect_request(exp_req);
            next_cycle();
        end
        mem_req_ready_i = 1'b1;
        @(negedge clk_i);
        expect_request(exp_req);
        next_cycle();
        mem_req_ready_i = 1'b0;
        @(negedge clk_i);
        expect_eq("mem_req_valid_o", mem_req_valid_o, 1'b0);
        send_line(cur);
        // Refill arbiter grant after the row's delay
        do @(negedge clk_i); while (!refill_req_valid_o);
        repeat (cur.grant_dly) begin
            next_cycle();
            @(negedge clk_i);
            expect_eq("refill_req_valid_o", refill_req_valid_o, 1'b1);
        end
        next_cycle();
        refill_req_ready_i = 1'b1;
        next_cycle();
        refill_req_ready_i = 1'b0;
        while (!dir_seen) @(posedge clk_i);
        // Response register answers one cycle after the matching write
        repeat (2) @(negedge clk_i);
        expect_eq("refill cycle count", wcyc, CL_WORDS);
        expect_eq("core response count", rsp_cnt, cur.need_rsp);
        expect_eq("data write count", wr_cnt, cur.error ? 0 : CL_WORDS);
        next_cycle();
        check_i       = 1'b1;
        check_nline_i = cur.nline;
        @(negedge clk_i);
        expect_eq("check_hit_o", check_hit_o, 1'b0);
        expect_eq("mshr_empty_o", mshr_empty_o, 1'b1);
        next_cycle();
        check_i = 1'b0;
        report_test(idx, $sformatf("line %h", cur.nline), errs_before);
    endtask

    // All four MSHR sets taken with no refill grant
    task automatic run_fill();
        int errs_before;
        errs_before     = err_cnt;
        mem_req_ready_i = 1'b1;
        for (int s = 0; s < 4; s++) begin
            alloc_req_i = '{nline: 27'h00abc00 + 27'(s), tid: 4'(s), sid: 3'd1, word: 2'd0,
                            victim_way: 2'(s), need_rsp: 1'b1};
            @(negedge clk_i);
            expect_eq("mshr_full_o", mshr_full_o, 1'b0);
            expect_true(alloc_ready_o && !alloc_full_o, "allocation refused on a free MSHR set");
            next_cycle();
            alloc_i = 1'b1;
            next_cycle();
            alloc_i = 1'b0;
            next_cycle();
        end
        @(negedge clk_i);
        expect_eq("mshr_full_o", mshr_full_o, 1'b1);
        expect_eq("mshr_empty_o", mshr_empty_o, 1'b0);
        expect_eq("refill_req_valid_o", refill_req_valid_o, 1'b0);
        report_test(NUM_ROWS, "MSHR fill", errs_before);
    endtask

    initial begin
        int total;
        seed               = 32'h80bd;
        rst_ni             = 1'b0;
        alloc_i            = 1'b0;
        alloc_req_i        = '0;
        check_i            = 1'b0;
        check_nline_i      = '0;
        mem_req_ready_i    = 1'b0;
        mem_resp_valid_i   = 1'b0;
        mem_resp_i         = '0;
        refill_req_ready_i = 1'b0;
        err_cnt            = 0;
        fail_tests         = 0;
        in_flight          = 1'b0;
        dir_seen           = 1'b0;
        wcyc               = 0;
        wr_cnt             = 0;
        rsp_cnt            = 0;
        cur                = '0;
        repeat (15) @(posedge clk_i);
        @(negedge clk_i);
        expect_eq("alloc_ready_o", alloc_ready_o, 1'b1);
        expect_eq("mem_req_valid_o", mem_req_valid_o, 1'b0);
        expect_eq("refill_req_valid_o", refill_req_valid_o, 1'b0);
        expect_eq("refill_write_data_o", refill_write_data_o, 1'b0);
        expect_eq("refill_write_dir_o", refill_write_dir_o, 1'b0);
        expect_eq("refill_updt_rtab_o", refill_updt_rtab_o, 1'b0);
        expect_eq("core_rsp_valid_o", core_rsp_valid_o, 1'b0);
        expect_eq("mshr_full_o", mshr_full_o, 1'b0);
        next_cycle();
        rst_ni = 1'b1;
        next_cycle();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        run_fill();
        total = err_cnt + dut_i.u_chk.fail_cnt;
        $display("Tests run %0d, tests with errors %0d, failed checks %0d",
                 NUM_TESTS, fail_tests, total);
        if (fail_tests == 0 && total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        repeat (16 + NUM_TESTS * 200) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles", 16 + NUM_TESTS * 200);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* miss_handler_chk.sv */
// Bound checks on the miss handler memory request, directory write and core response
`default_nettype none
`timescale 1ns/1ps

module miss_handler_chk
    import mh_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire logic      mem_req_valid_i,
    input  wire logic      mem_req_ready_i,
    input  wire mem_req_t  mem_req_i,
    input  wire logic      refill_write_dir_i,
    input  wire word_t     refill_word_i,
    input  wire logic      core_rsp_valid_i
);

    // Read by the testbench at the end of the run
    int fail_cnt = 0;

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
        else begin
            fail_cnt++;
            $error("memory request dropped or changed under back-pressure");
        end

    a_dir_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_write_dir_i |-> refill_word_i == word_t'(CL_WORDS - 1))
        else begin
            fail_cnt++;
            $error("directory write outside the last chunk");
        end

    // The response register holds one entry for a single cycle
    a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_i |=> !core_rsp_valid_i)
        else begin
            fail_cnt++;
            $error("core response valid for two cycles");
        end

endmodule

bind miss_handler miss_handler_chk u_chk (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .mem_req_valid_i(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_req_i(mem_req_o),
    .refill_write_dir_i(refill_write_dir_o),
    .refill_word_i(refill_word_o),
    .core_rsp_valid_i(core_rsp_valid_o)
);

`default_nettype wire

/* miss_handler.sv */
// Cache miss handler top level joining request, MSHR, response buffer and refill control
`default_nettype none
`timescale 1ns/1ps

module miss_handler
    import mh_pkg::*;
#(
    parameter int unsigned MSHR_SETS  = 4,
    parameter int unsigned META_DEPTH = 2
) (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,

    // Allocation and pending-line check
    input  wire logic        alloc_i,
    input  wire alloc_req_t  alloc_req_i,
    output logic             alloc_ready_o,
    output logic             alloc_full_o,
    input  wire logic        check_i,
    input  wire nline_t      check_nline_i,
    output logic             check_hit_o,
    output logic             mshr_empty_o,
    output logic             mshr_full_o,

    // Memory side
    input  wire logic        mem_req_ready_i,
    output logic             mem_req_valid_o,
    output mem_req_t         mem_req_o,
    input  wire logic        mem_resp_valid_i,
    input  wire mem_rsp_t    mem_resp_i,
    output logic             mem_resp_ready_o,

    // Cache refill side
    input  wire logic        refill_req_ready_i,
    output logic             refill_req_valid_o,
    output logic             refill_busy_o,
    output logic             refill_write_data_o,
    output logic             refill_write_dir_o,
    output logic             refill_updt_rtab_o,
    output logic             refill_is_error_o,
    output set_t             refill_set_o,
    output way_t             refill_way_o,
    output word_t            refill_word_o,
    output nline_t           refill_nline_o,
    output data_t            refill_data_o,
    output dir_entry_t       refill_dir_entry_o,

    output logic             core_rsp_valid_o,
    output core_rsp_t        core_rsp_o
);

    logic        alloc_take;
    logic        mshr_empty;
    logic        meta_valid;
    resp_meta_t  meta;
    logic        meta_pop;
    logic        data_pop;
    data_t       resp_data;
    logic        ack;
    mshr_set_t   ack_id;
    nline_t      ack_nline;
    mshr_entry_t ack_entry;

    mh_miss_req u_miss_req (
        .clk_i, .rst_ni,
        .alloc_i, .alloc_nline_i(alloc_req_i.nline), .alloc_ready_o,
        .alloc_take_o(alloc_take),
        .mem_req_ready_i, .mem_req_valid_o, .mem_req_o
    );

    mh_mshr #(.MSHR_SETS(MSHR_SETS)) u_mshr (
        .clk_i, .rst_ni,
        .alloc_i(alloc_take), .alloc_req_i, .alloc_full_o,
        .check_i, .check_nline_i, .check_hit_o,
        .ack_i(ack), .ack_id_i(ack_id), .ack_nline_o(ack_nline), .ack_entry_o(ack_entry),
        .empty_o(mshr_empty), .full_o(mshr_full_o)
    );

    mh_resp_buf #(.META_DEPTH(META_DEPTH)) u_resp_buf (
        .clk_i, .rst_ni,
        .mem_resp_valid_i, .mem_resp_i, .mem_resp_ready_o,
        .meta_valid_o(meta_valid), .meta_o(meta), .meta_pop_i(meta_pop),
        .data_o(resp_data), .data_pop_i(data_pop)
    );

    mh_refill_ctrl u_refill_ctrl (
        .clk_i, .rst_ni,
        .meta_valid_i(meta_valid), .meta_i(meta), .meta_pop_o(meta_pop),
        .data_pop_o(data_pop), .data_i(resp_data),
        .refill_req_ready_i, .refill_req_valid_o,
        .ack_o(ack), .ack_id_o(ack_id), .ack_nline_i(ack_nline), .ack_entry_i(ack_entry),
        .refill_busy_o, .refill_write_data_o, .refill_write_dir_o, .refill_updt_rtab_o,
        .refill_is_error_o, .refill_set_o, .refill_way_o, .refill_word_o,
        .refill_nline_o, .refill_data_o, .refill_dir_entry_o,
        .core_rsp_valid_o, .core_rsp_o
    );

    // No miss is in flight once the slots are free and the last refill is done
    assign mshr_empty_o = mshr_empty & ~refill_busy_o;

endmodule

`default_nettype wire

/* mh_refill_ctrl.sv */
// Refill controller sequencing cache data and directory writes and the core response
`default_nettype none
`timescale 1ns/1ps

module mh_refill_ctrl
    import mh_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_ni,

    input  wire logic         meta_valid_i,
    input  wire resp_meta_t   meta_i,
    output logic              meta_pop_o,
    output logic              data_pop_o,
    input  wire data_t        data_i,

    input  wire logic         refill_req_ready_i,
    output logic              refill_req_valid_o,

    output logic              ack_o,
    output mshr_set_t         ack_id_o,
    input  wire nline_t       ack_nline_i,
    input  wire mshr_entry_t  ack_entry_i,

    output logic              refill_busy_o,
    output logic              refill_write_data_o,
    output logic              refill_write_dir_o,
    output logic              refill_updt_rtab_o,
    output logic              refill_is_error_o,
    output set_t              refill_set_o,
    output way_t              refill_way_o,
    output word_t             refill_word_o,
    output nline_t            refill_nline_o,
    output data_t             refill_data_o,
    output dir_entry_t        refill_dir_entry_o,

    output logic              core_rsp_valid_o,
    output core_rsp_t         core_rsp_o
);

    refill_state_e state_q, state_d;
    word_t         cnt_q, cnt_d;
    nline_t        nline_q;
    mshr_entry_t   entry_q;
    logic          rsp_load;
    logic          rsp_valid_q;
    core_rsp_t     rsp_q;

    // The head metadata stays in place for the whole refill
    assign refill_is_error_o = meta_i.error;
    assign ack_id_o          = meta_i.id;

    always_comb begin
        refill_req_valid_o  = 1'b0;
        ack_o               = 1'b0;
        data_pop_o          = 1'b0;
        meta_pop_o          = 1'b0;
        refill_write_data_o = 1'b0;
        refill_write_dir_o  = 1'b0;
        refill_updt_rtab_o  = 1'b0;
        rsp_load            = 1'b0;
        cnt_d               = cnt_q;
        state_d             = state_q;

        unique case (state_q)
            REFILL_IDLE: begin
                refill_req_valid_o = meta_valid_i;
                if (meta_valid_i && refill_req_ready_i) begin
                    // Free the MSHR slot and latch its contents
                    ack_o   = 1'b1;
                    cnt_d   = '0;
                    state_d = REFILL_WRITE;
                end
            end
            REFILL_WRITE: begin
                data_pop_o          = 1'b1;
                refill_write_data_o = ~meta_i.error;
                rsp_load            = entry_q.need_rsp & (cnt_q == entry_q.word);
                cnt_d               = cnt_q + 1'b1;
                if (cnt_q == word_t'(CL_WORDS - 1)) begin
                    refill_write_dir_o = 1'b1;
                    refill_updt_rtab_o = 1'b1;
                    meta_pop_o         = 1'b1;
                    state_d            = REFILL_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= REFILL_IDLE;
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            rsp_valid_q <= rsp_load;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ack_o) begin
            nline_q <= ack_nline_i;
            entry_q <= ack_entry_i;
        end
        if (rsp_load) begin
            rsp_q <= '{data: data_i, sid: entry_q.sid, tid: entry_q.tid, error: meta_i.error};
        end
    end

    assign refill_busy_o  = (state_q != REFILL_IDLE);
    assign refill_set_o   = nline_q[6:0];
    assign refill_way_o   = entry_q.way;
    assign refill_word_o  = cnt_q;
    assign refill_nline_o = nline_q;
    assign refill_data_o  = data_i;

    // An error leaves the preallocated line invalid
    assign refill_dir_entry_o = '{valid: ~meta_i.error, tag: nline_q[26:7]};

    // One-deep response register, the core never stalls
    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_o       = rsp_q;

endmodule

`default_nettype wire

/* mh_resp_buf.sv */
// Memory response buffer holding refill data beats and per-line metadata
`default_nettype none
`timescale 1ns/1ps

module mh_resp_buf
    import mh_pkg::*;
#(
    parameter int unsigned META_DEPTH = 2
) (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,

    input  wire logic      mem_resp_valid_i,
    input  wire mem_rsp_t  mem_resp_i,
    output logic           mem_resp_ready_o,

    output logic           meta_valid_o,
    output resp_meta_t     meta_o,
    input  wire logic      meta_pop_i,

    output data_t          data_o,
    input  wire logic      data_pop_i
);

    localparam int unsigned DATA_DEPTH = META_DEPTH * CL_WORDS;
    localparam int unsigned DPTR_W     = $clog2(DATA_DEPTH);
    localparam int unsigned DCNT_W     = $clog2(DATA_DEPTH + 1);
    localparam int unsigned MPTR_W     = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
    localparam int unsigned MCNT_W     = $clog2(META_DEPTH + 1);

    data_t              data_mem [DATA_DEPTH];
    logic [DPTR_W-1:0]  data_wr_q, data_rd_q;
    logic [DCNT_W-1:0]  data_cnt_q;

    resp_meta_t         meta_mem [META_DEPTH];
    logic [MPTR_W-1:0]  meta_wr_q, meta_rd_q;
    logic [MCNT_W-1:0]  meta_cnt_q;

    logic               data_wok, meta_wok;
    logic               data_push, meta_push;

    assign data_wok = (data_cnt_q != DCNT_W'(DATA_DEPTH));
    assign meta_wok = (meta_cnt_q != MCNT_W'(META_DEPTH));

    // The last beat is only taken if its metadata fits too
    assign mem_resp_ready_o = mem_resp_valid_i & data_wok & (meta_wok | ~mem_resp_i.last);
    assign data_push        = mem_resp_ready_o;
    assign meta_push        = mem_resp_ready_o & mem_resp_i.last;

    assign data_o       = data_mem[data_rd_q];
    assign meta_o       = meta_mem[meta_rd_q];
    assign meta_valid_o = (meta_cnt_q != '0);

    // Data beats
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_wr_q  <= '0;
            data_rd_q  <= '0;
            data_cnt_q <= '0;
        end else begin
            if (data_push) begin
                data_wr_q <= (data_wr_q == DPTR_W'(DATA_DEPTH - 1)) ? '0 : data_wr_q + 1'b1;
            end
            if (data_pop_i) begin
                data_rd_q <= (data_rd_q == DPTR_W'(DATA_DEPTH - 1)) ? '0 : data_rd_q + 1'b1;
            end
            data_cnt_q <= data_cnt_q + DCNT_W'(data_push) - DCNT_W'(data_pop_i);
        end
    end

    // Line metadata
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            meta_wr_q  <= '0;
            meta_rd_q  <= '0;
            meta_cnt_q <= '0;
        end else begin
            if (meta_push) begin
                meta_wr_q <= (meta_wr_q == MPTR_W'(META_DEPTH - 1)) ? '0 : meta_wr_q + 1'b1;
            end
            if (meta_pop_i) begin
                meta_rd_q <= (meta_rd_q == MPTR_W'(META_DEPTH - 1)) ? '0 : meta_rd_q + 1'b1;
            end
            meta_cnt_q <= meta_cnt_q + MCNT_W'(meta_push) - MCNT_W'(meta_pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_push) begin
            data_mem[data_wr_q] <= mem_resp_i.data;
        end
        if (meta_push) begin
            meta_mem[meta_wr_q] <= '{error: mem_resp_i.error, id: mem_resp_i.id};
        end
    end

endmodule

`default_nettype wire

/* mh_mshr.sv */
// Miss status holding registers, one entry per set, with allocate, check and acknowledge
`default_nettype none
`timescale 1ns/1ps

module mh_mshr
    import mh_pkg::*;
#(
    parameter int unsigned MSHR_SETS = 4
) (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,

    input  wire logic        alloc_i,
    input  wire alloc_req_t  alloc_req_i,
    output logic             alloc_full_o,

    input  wire logic        check_i,
    input  wire nline_t      check_nline_i,
    output logic             check_hit_o,

    input  wire logic        ack_i,
    input  wire mshr_set_t   ack_id_i,
    output nline_t           ack_nline_o,
    output mshr_entry_t      ack_entry_o,

    output logic             empty_o,
    output logic             full_o
);

    logic [MSHR_SETS-1:0] valid_q;
    mshr_entry_t          entry_q [MSHR_SETS];

    int unsigned          alloc_idx;
    int unsigned          check_idx;
    int unsigned          ack_idx;
    mshr_entry_t          alloc_entry;

    // Slot selected by the low line-number bits
    function automatic int unsigned set_idx(mshr_set_t s);
        return int'(s) % MSHR_SETS;
    endfunction

    assign alloc_idx = set_idx(alloc_req_i.nline[MSHR_IDX_W-1:0]);
    assign check_idx = set_idx(check_nline_i[MSHR_IDX_W-1:0]);
    assign ack_idx   = set_idx(ack_id_i);

    assign alloc_entry.ntag     = alloc_req_i.nline[26:MSHR_IDX_W];
    assign alloc_entry.tid      = alloc_req_i.tid;
    assign alloc_entry.sid      = alloc_req_i.sid;
    assign alloc_entry.word     = alloc_req_i.word;
    assign alloc_entry.way      = alloc_req_i.victim_way;
    assign alloc_entry.need_rsp = alloc_req_i.need_rsp;

    // Caller must hold off while the target slot is busy
    assign alloc_full_o = valid_q[alloc_idx];

    assign check_hit_o = check_i & valid_q[check_idx] &
                         (entry_q[check_idx].ntag == check_nline_i[26:MSHR_IDX_W]);

    // The memory id carries the index bits back with the response
    assign ack_entry_o = entry_q[ack_idx];
    assign ack_nline_o = {entry_q[ack_idx].ntag, ack_id_i};

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (ack_i) begin
                valid_q[ack_idx] <= 1'b0;
            end
            if (alloc_i) begin
                valid_q[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            entry_q[alloc_idx] <= alloc_entry;
        end
    end

endmodule

`default_nettype wire

/* mh_miss_req.sv */
// Miss request block that accepts one allocation and issues its line read to memory
`default_nettype none
`timescale 1ns/1ps

module mh_miss_req
    import mh_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,

    input  wire logic     alloc_i,
    input  wire nline_t   alloc_nline_i,
    output logic          alloc_ready_o,
    output logic          alloc_take_o,

    input  wire logic     mem_req_ready_i,
    output logic          mem_req_valid_o,
    output mem_req_t      mem_req_o
);

    miss_req_state_e state_q, state_d;
    nline_t          nline_q;

    always_comb begin
        alloc_ready_o   = 1'b0;
        alloc_take_o    = 1'b0;
        mem_req_valid_o = 1'b0;
        state_d         = state_q;

        unique case (state_q)
            MISS_REQ_IDLE: begin
                alloc_ready_o = 1'b1;
                alloc_take_o  = alloc_i;
                if (alloc_i) begin
                    state_d = MISS_REQ_SEND;
                end
            end
            MISS_REQ_SEND: begin
                // Hold the request until memory takes it
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    state_d = MISS_REQ_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MISS_REQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_take_o) begin
            nline_q <= alloc_nline_i;
        end
    end

    // Full line burst, the id selects the MSHR set on the way back
    assign mem_req_o.addr = {nline_q, {CL_OFFSET_W{1'b0}}};
    assign mem_req_o.len  = len_t'(CL_WORDS - 1);
    assign mem_req_o.id   = nline_q[MSHR_IDX_W-1:0];

endmodule

`default_nettype wire

/* mh_pkg.sv */
// Miss handler package with widths, shared types, payload structs and state encodings
`default_nettype none

package mh_pkg;

    // Line geometry and bus width
    localparam int unsigned MEM_DATA_W  = 64;
    localparam int unsigned CL_WORDS    = 4;
    localparam int unsigned CL_OFFSET_W = 5;

    // The MSHR index is taken from the low line-number bits
    localparam int unsigned MSHR_IDX_W  = 2;
    localparam int unsigned MSHR_NTAG_W = 27 - MSHR_IDX_W;

    typedef logic [31:0]             addr_t;
    typedef logic [26:0]             nline_t;
    typedef logic [6:0]              set_t;
    typedef logic [19:0]             tag_t;
    typedef logic [1:0]              way_t;
    typedef logic [1:0]              word_t;
    typedef logic [MEM_DATA_W-1:0]   data_t;
    typedef logic [2:0]              sid_t;
    typedef logic [3:0]              tid_t;
    typedef logic [MSHR_IDX_W-1:0]   mshr_set_t;
    typedef logic [7:0]              len_t;

    typedef struct packed {
        nline_t nline;
        tid_t   tid;
        sid_t   sid;
        word_t  word;
        way_t   victim_way;
        logic   need_rsp;
    } alloc_req_t;

    // Stored entry, the index bits are implied by the slot
    typedef struct packed {
        logic [MSHR_NTAG_W-1:0] ntag;
        tid_t                   tid;
        sid_t                   sid;
        word_t                  word;
        way_t                   way;
        logic                   need_rsp;
    } mshr_entry_t;

    typedef struct packed {
        addr_t     addr;
        len_t      len;
        mshr_set_t id;
    } mem_req_t;

    typedef struct packed {
        data_t     data;
        mshr_set_t id;
        logic      error;
        logic      last;
    } mem_rsp_t;

    typedef struct packed {
        logic      error;
        mshr_set_t id;
    } resp_meta_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    typedef struct packed {
        data_t data;
        sid_t  sid;
        tid_t  tid;
        logic  error;
    } core_rsp_t;

    typedef enum logic {
        REFILL_IDLE,
        REFILL_WRITE
    } refill_state_e;

    typedef enum logic {
        MISS_REQ_IDLE,
        MISS_REQ_SEND
    } miss_req_state_e;

endpackage

`default_nettype wire
